/* common/mem_pkg.sv */
// Memory port package holding the read port widths and its request and response structs
`default_nettype none

package mem_pkg;

    ////////////////////////////////////////////////////////////
    // Port widths
    ////////////////////////////////////////////////////////////

    // Address and read data of the SRAM-style port
    localparam int unsigned MEM_ADDR_W = 32;
    localparam int unsigned MEM_DATA_W = 32;

    ////////////////////////////////////////////////////////////
    // Read port structs
    ////////////////////////////////////////////////////////////

    // Driven by the stage towards memory
    typedef struct packed {
        logic                  req;
        logic [MEM_ADDR_W-1:0] addr;
    } mem_req_t;

    // Driven by memory back into the stage
    // One valid per granted request, in grant order
    typedef struct packed {
        logic                  gnt;
        logic                  valid;
        logic [MEM_DATA_W-1:0] rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

/* common/mpt_pkg.sv */
// Walker package with the transaction struct, the walk flag and the queue sizing
`default_nettype none

package mpt_pkg;

    // Address and data widths come from the memory port
    import mem_pkg::*;

    ////////////////////////////////////////////////////////////
    // Sizing
    ////////////////////////////////////////////////////////////

    localparam int unsigned TXN_ID_W       = 4;
    // Depth of each queue, also the admission limit of the stage
    localparam int unsigned TXN_FIFO_DEPTH = 4;
    // One queue counts 0 to TXN_FIFO_DEPTH
    localparam int unsigned TXN_USAGE_W    = 3;
    // Sum of both queue counts
    localparam int unsigned STAGE_USAGE_W  = 4;

    ////////////////////////////////////////////////////////////
    // Transaction
    ////////////////////////////////////////////////////////////

    // Tells whether the stage reads memory for this transaction
    typedef enum logic {
        MPT_WALK_SKIP = 1'b0,
        MPT_WALK_DO   = 1'b1
    } mpt_walk_e;

    // Walker transaction as seen by the read stage
    typedef struct packed {
        logic [TXN_ID_W-1:0]   id;
        mpt_walk_e             walking;
        logic [1:0]            access_type;
        logic                  access_error;
        // Supervisor physical address, used as read address
        logic [MEM_ADDR_W-1:0] spa;
        // Filled with the read data of a walk
        logic [MEM_DATA_W-1:0] rpa;
    } mpt_txn_t;

endpackage

`default_nettype wire

/* rtl/transaction_fifo.sv */
// Transaction queue with registered head and usage count, for granted and completed entries
`default_nettype none
`timescale 1ns/100ps

module transaction_fifo import mpt_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   push_i,
    input  mpt_txn_t               data_i,
    input  logic                   pop_i,
    output mpt_txn_t               data_o,
    output logic                   empty_o,
    output logic                   full_o,
    output logic [TXN_USAGE_W-1:0] usage_o
);

    mpt_txn_t                          mem_q [TXN_FIFO_DEPTH];
    logic [$clog2(TXN_FIFO_DEPTH)-1:0] wr_ptr_q;
    logic [$clog2(TXN_FIFO_DEPTH)-1:0] rd_ptr_q;
    logic [TXN_USAGE_W-1:0]            usage_q;

    // Head always visible, no fall-through from data_i
    assign data_o  = mem_q[rd_ptr_q];
    assign usage_o = usage_q;
    assign empty_o = (usage_q == '0);
    assign full_o  = (usage_q == TXN_USAGE_W'(TXN_FIFO_DEPTH));

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            usage_q  <= '0;
        end else begin
            // Power of two depth, pointers wrap on their own
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   usage_q <= usage_q + 1'b1;
                2'b01:   usage_q <= usage_q - 1'b1;
                default: usage_q <= usage_q;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // Callers rely on admission rather than checking flags
    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_i |-> !full_o);
    a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_i |-> !empty_o);

endmodule

`default_nettype wire

/* rtl/req_register.sv */
// Single-entry pipeline register decoupling the previous stage from grant control
`default_nettype none
`timescale 1ns/100ps

module req_register import mpt_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     s_valid_i,
    input  mpt_txn_t s_txn_i,
    output logic     s_ready_o,
    output logic     m_valid_o,
    output mpt_txn_t m_txn_o,
    input  logic     m_ready_i
);

    logic     full_q;
    // Low during reset and the first cycle after it
    logic     active_q;
    mpt_txn_t txn_q;
    logic     load;
    logic     unload;

    assign m_valid_o = full_q;
    assign m_txn_o   = txn_q;

    // Room when empty, or when the held entry leaves this cycle
    assign s_ready_o = active_q & (~full_q | m_ready_i);
    assign load      = s_valid_i & s_ready_o;
    assign unload    = full_q & m_ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            active_q <= 1'b0;
            full_q   <= 1'b0;
        end else begin
            active_q <= 1'b1;
            // A load wins over an unload in the same cycle
            if (load) begin
                full_q <= 1'b1;
            end else if (unload) begin
                full_q <= 1'b0;
            end
        end
    end

    // Payload only
    always_ff @(posedge clk_i) begin
        if (load) begin
            txn_q <= s_txn_i;
        end
    end

    // Grant control reads the spa over several cycles while waiting for gnt
    a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (m_valid_o && !m_ready_i) |=> $stable(m_txn_o));

endmodule

`default_nettype wire

/* rtl/grant_ctrl.sv */
// Grant control admitting transactions and issuing the memory read request of a walk
`default_nettype none
`timescale 1ns/100ps

module grant_ctrl
    import mem_pkg::*;
    import mpt_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   txn_valid_i,
    input  mpt_txn_t               txn_i,
    output logic                   txn_ready_o,
    input  logic [TXN_USAGE_W-1:0] gq_usage_i,
    input  logic [TXN_USAGE_W-1:0] cq_usage_i,
    output logic                   gq_push_o,
    output mem_req_t               mem_req_o,
    input  logic                   mem_gnt_i
);

    typedef enum logic {
        GNT_IDLE,
        GNT_WAIT
    } gnt_state_e;

    gnt_state_e               state_q;
    gnt_state_e               state_d;
    logic [STAGE_USAGE_W-1:0] stage_usage;
    logic                     admit;
    logic                     do_walk;

    // Both queues together must have room for the whole path of a transaction
    assign stage_usage = STAGE_USAGE_W'(gq_usage_i) + STAGE_USAGE_W'(cq_usage_i);
    assign admit       = stage_usage < STAGE_USAGE_W'(TXN_FIFO_DEPTH);
    assign do_walk     = (txn_i.walking == MPT_WALK_DO);

    ////////////////////////////////////////////////////////////
    // Request FSM
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_d     = state_q;
        mem_req_o   = '0;
        gq_push_o   = 1'b0;
        txn_ready_o = 1'b0;
        case (state_q)
            GNT_IDLE: begin
                if (txn_valid_i && admit) begin
                    if (do_walk) begin
                        mem_req_o.req  = 1'b1;
                        mem_req_o.addr = txn_i.spa;
                        // gnt may already be high without a request
                        if (mem_gnt_i) begin
                            gq_push_o   = 1'b1;
                            txn_ready_o = 1'b1;
                        end else begin
                            state_d = GNT_WAIT;
                        end
                    end else begin
                        // No memory access, straight into the grant queue
                        gq_push_o   = 1'b1;
                        txn_ready_o = 1'b1;
                    end
                end
            end
            GNT_WAIT: begin
                // Usage can only drop here, so admission still holds
                mem_req_o.req  = 1'b1;
                mem_req_o.addr = txn_i.spa;
                if (mem_gnt_i) begin
                    gq_push_o   = 1'b1;
                    txn_ready_o = 1'b1;
                    state_d     = GNT_IDLE;
                end
            end
            default: begin
                state_d = GNT_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= GNT_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Request held with the same address until memory takes it
    a_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (state_q == GNT_WAIT) |-> (mem_req_o.req && $stable(mem_req_o.addr)));

endmodule

`default_nettype wire

/* rtl/response_ctrl.sv */
// Response control matching read data to granted transactions in order and driving the output port
`default_nettype none
`timescale 1ns/100ps

module response_ctrl
    import mem_pkg::*;
    import mpt_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_ni,
    // Grant queue head
    input  mpt_txn_t              gq_txn_i,
    input  logic                  gq_empty_i,
    output logic                  gq_pop_o,
    // Completion queue write side
    output logic                  cq_push_o,
    output mpt_txn_t              cq_txn_o,
    input  logic                  cq_full_i,
    // Completion queue head
    input  mpt_txn_t              cq_head_i,
    input  logic                  cq_empty_i,
    output logic                  cq_pop_o,
    // Memory response
    input  logic                  mem_valid_i,
    input  logic [MEM_DATA_W-1:0] mem_rdata_i,
    // Next stage
    output logic                  out_valid_o,
    input  logic                  out_ready_i,
    output mpt_txn_t              out_txn_o
);

    // Held responses, waiting for their walking entry to reach the head
    logic [MEM_DATA_W-1:0]             hold_mem_q [TXN_FIFO_DEPTH];
    logic [$clog2(TXN_FIFO_DEPTH)-1:0] hold_wr_q;
    logic [$clog2(TXN_FIFO_DEPTH)-1:0] hold_rd_q;
    logic [TXN_USAGE_W-1:0]            hold_cnt_q;

    logic                  hold_have;
    logic                  hold_push;
    logic                  hold_pop;
    logic                  head_walk;
    logic                  move;
    logic [MEM_DATA_W-1:0] rsp_data;

    ////////////////////////////////////////////////////////////
    // Completion of the grant queue head
    ////////////////////////////////////////////////////////////

    assign hold_have = (hold_cnt_q != '0);
    assign head_walk = (gq_txn_i.walking == MPT_WALK_DO);

    // A walk completes once its data exists, held or arriving now
    assign move = ~gq_empty_i & ~cq_full_i & (~head_walk | hold_have | mem_valid_i);

    // Oldest held data belongs to the head before any arriving word
    assign rsp_data = hold_have ? hold_mem_q[hold_rd_q] : mem_rdata_i;

    always_comb begin
        cq_txn_o = gq_txn_i;
        if (head_walk) begin
            cq_txn_o.rpa = rsp_data;
        end
    end

    assign gq_pop_o  = move;
    assign cq_push_o = move;

    // Arriving data is held unless the head consumes it directly
    assign hold_pop  = move & head_walk & hold_have;
    assign hold_push = mem_valid_i & ~(move & head_walk & ~hold_have);

    ////////////////////////////////////////////////////////////
    // Held-response queue
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            hold_wr_q  <= '0;
            hold_rd_q  <= '0;
            hold_cnt_q <= '0;
        end else begin
            if (hold_push) begin
                hold_wr_q <= hold_wr_q + 1'b1;
            end
            if (hold_pop) begin
                hold_rd_q <= hold_rd_q + 1'b1;
            end
            case ({hold_push, hold_pop})
                2'b10:   hold_cnt_q <= hold_cnt_q + 1'b1;
                2'b01:   hold_cnt_q <= hold_cnt_q - 1'b1;
                default: hold_cnt_q <= hold_cnt_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (hold_push) begin
            hold_mem_q[hold_wr_q] <= mem_rdata_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // Output port
    ////////////////////////////////////////////////////////////

    // Always served from the completion queue head
    assign out_valid_o = ~cq_empty_i;
    assign out_txn_o   = cq_head_i;
    assign cq_pop_o    = ~cq_empty_i & out_ready_i;

    // Admission bounds outstanding reads to the queue depth
    a_hold_room: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_valid_i |-> (hold_cnt_q != TXN_USAGE_W'(TXN_FIFO_DEPTH)));

endmodule

`default_nettype wire

/* rtl/memory_read_stage.sv */
// Memory read stage of the protection table walker, issuing one SRAM read per walking transaction
`default_nettype none
`timescale 1ns/100ps

module memory_read_stage
    import mem_pkg::*;
    import mpt_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_ni,
    // From the previous stage
    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  mpt_txn_t in_txn_i,
    // To the next stage
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output mpt_txn_t out_txn_o,
    // SRAM read port
    output mem_req_t mem_req_o,
    input  mem_rsp_t mem_rsp_i
);

    // Input register to grant control
    logic                   reg_valid;
    logic                   reg_ready;
    mpt_txn_t               reg_txn;

    // Grant queue
    logic                   gq_push;
    logic                   gq_pop;
    mpt_txn_t               gq_txn;
    logic                   gq_empty;
    logic [TXN_USAGE_W-1:0] gq_usage;

    // Completion queue
    logic                   cq_push;
    logic                   cq_pop;
    mpt_txn_t               cq_txn;
    mpt_txn_t               cq_head;
    logic                   cq_empty;
    logic                   cq_full;
    logic [TXN_USAGE_W-1:0] cq_usage;

    ////////////////////////////////////////////////////////////
    // Input side
    ////////////////////////////////////////////////////////////

    req_register u_req_reg (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .s_valid_i (in_valid_i),
        .s_txn_i   (in_txn_i),
        .s_ready_o (in_ready_o),
        .m_valid_o (reg_valid),
        .m_txn_o   (reg_txn),
        .m_ready_i (reg_ready)
    );

    // Admission and request issue
    grant_ctrl u_grant_ctrl (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .txn_valid_i (reg_valid),
        .txn_i       (reg_txn),
        .txn_ready_o (reg_ready),
        .gq_usage_i  (gq_usage),
        .cq_usage_i  (cq_usage),
        .gq_push_o   (gq_push),
        .mem_req_o   (mem_req_o),
        .mem_gnt_i   (mem_rsp_i.gnt)
    );

    ////////////////////////////////////////////////////////////
    // Queues and completion
    ////////////////////////////////////////////////////////////

    // Admission keeps this queue from filling, so full is left open
    transaction_fifo u_grant_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (gq_push),
        .data_i  (reg_txn),
        .pop_i   (gq_pop),
        .data_o  (gq_txn),
        .empty_o (gq_empty),
        .full_o  (),
        .usage_o (gq_usage)
    );

    transaction_fifo u_cpl_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (cq_push),
        .data_i  (cq_txn),
        .pop_i   (cq_pop),
        .data_o  (cq_head),
        .empty_o (cq_empty),
        .full_o  (cq_full),
        .usage_o (cq_usage)
    );

    response_ctrl u_rsp_ctrl (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .gq_txn_i    (gq_txn),
        .gq_empty_i  (gq_empty),
        .gq_pop_o    (gq_pop),
        .cq_push_o   (cq_push),
        .cq_txn_o    (cq_txn),
        .cq_full_i   (cq_full),
        .cq_head_i   (cq_head),
        .cq_empty_i  (cq_empty),
        .cq_pop_o    (cq_pop),
        .mem_valid_i (mem_rsp_i.valid),
        .mem_rdata_i (mem_rsp_i.rdata),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_txn_o   (out_txn_o)
    );

endmodule

`default_nettype wire

/* dv/tb_memory_read_stage.sv */
// Testbench for the memory read stage with random traffic, a memory responder and an in-order model
`default_nettype none
`timescale 1ns/100ps

module tb_memory_read_stage
    import mem_pkg::*;
    import mpt_pkg::*;
;

    localparam int          NUM_TXN     = 300;
    localparam int          END_TIMEOUT = 20000;
    localparam int          STALL_LIMIT = 200;
    localparam logic [31:0] RDATA_MASK  = 32'hA5A5_5A5A;

    logic     clk_i;
    logic     rst_ni;
    logic     in_valid_i;
    logic     in_ready_o;
    mpt_txn_t in_txn_i;
    logic     out_valid_o;
    logic     out_ready_i;
    mpt_txn_t out_txn_o;
    mem_req_t mem_req_o;
    mem_rsp_t mem_rsp_i;

    integer      seed;
    logic        started;
    int unsigned cycle;
    int unsigned last_due;
    int          sent;
    int          accepted;
    int          delivered;
    int          in_stall_cnt;

    // Previous cycle state for the hold checks
    logic     req_waiting;
    mem_req_t last_req;
    logic     out_stalled;
    mpt_txn_t last_out;

    // Model queues, accepted transactions and walk addresses in input order
    mpt_txn_t              exp_txn_q [$];
    logic [MEM_ADDR_W-1:0] exp_addr_q [$];
    // Responder queues, due cycle and read data per granted request
    int unsigned           rsp_due_q [$];
    logic [MEM_DATA_W-1:0] rsp_data_q [$];

    memory_read_stage DUT (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_txn_i    (in_txn_i),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_txn_o   (out_txn_o),
        .mem_req_o   (mem_req_o),
        .mem_rsp_i   (mem_rsp_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    task automatic fail_stop();
        $display("** FAIL **");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_txn(input string name, input mpt_txn_t got, input mpt_txn_t exp);
        if (got !== exp) begin
            $display("ERR %s: got %h expected %h", name, got, exp);
            fail_stop();
        end
    endtask

    task automatic check_mem_req(input string name, input mem_req_t got, input mem_req_t exp);
        if (got !== exp) begin
            $display("ERR %s: got %h expected %h", name, got, exp);
            fail_stop();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s: got %h expected %h", name, got, exp);
            fail_stop();
        end
    endtask

    // A walk returns the read data of its spa, a skip keeps its rpa
    function automatic mpt_txn_t expected_output(input mpt_txn_t in_txn);
        mpt_txn_t res;
        res = in_txn;
        if (in_txn.walking == MPT_WALK_DO) begin
            res.rpa = in_txn.spa ^ RDATA_MASK;
        end
        return res;
    endfunction

    ////////////////////////////////////////////////////////////
    // Stimulus and memory responder
    ////////////////////////////////////////////////////////////

    always @(posedge clk_i) begin : drive_stimulus
        logic [31:0] rnd;
        int unsigned due;
        mpt_txn_t    txn;
        if (started) begin
            cycle = cycle + 1;
            rnd   = $random(seed);
            // Next transaction once the previous one is taken on this edge
            if (!in_valid_i || in_ready_o) begin
                if ((sent < NUM_TXN) && (rnd[5:4] != 2'b00)) begin
                    txn.id           = TXN_ID_W'(sent);
                    txn.walking      = rnd[8] ? MPT_WALK_DO : MPT_WALK_SKIP;
                    txn.access_type  = rnd[10:9];
                    txn.access_error = rnd[11];
                    txn.spa          = $random(seed);
                    txn.rpa          = $random(seed);
                    in_valid_i <= 1'b1;
                    in_txn_i   <= txn;
                    sent = sent + 1;
                end else begin
                    in_valid_i <= 1'b0;
                end
            end
            out_ready_i   <= (rnd[3:2] != 2'b00);
            mem_rsp_i.gnt <= (rnd[1:0] != 2'b00);
            // Granted read answered 1 to 4 cycles later, never before an older one
            if (mem_req_o.req && mem_rsp_i.gnt) begin
                due = cycle + 1 + rnd[7:6];
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                rsp_due_q.push_back(due);
                rsp_data_q.push_back(mem_req_o.addr ^ RDATA_MASK);
            end
            // Driven now, seen by the DUT on the next edge
            if ((rsp_due_q.size() != 0) && (rsp_due_q[0] <= cycle + 1)) begin
                due = rsp_due_q.pop_front();
                mem_rsp_i.valid <= 1'b1;
                mem_rsp_i.rdata <= rsp_data_q.pop_front();
            end else begin
                mem_rsp_i.valid <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Port monitor and model
    ////////////////////////////////////////////////////////////

    always @(posedge clk_i) begin : monitor_ports
        mem_req_t exp_req;
        if (started) begin
            if (in_valid_i && in_ready_o) begin
                exp_txn_q.push_back(in_txn_i);
                if (in_txn_i.walking == MPT_WALK_DO) begin
                    exp_addr_q.push_back(in_txn_i.spa);
                end
                accepted = accepted + 1;
            end
            // Input port must not stall forever
            if (in_valid_i && !in_ready_o) begin
                in_stall_cnt = in_stall_cnt + 1;
            end else begin
                in_stall_cnt = 0;
            end
            if (in_stall_cnt > STALL_LIMIT) begin
                $display("Input port not ready for too many cycles");
                fail_stop();
            end
            // Ungranted request keeps req and addr
            if (req_waiting) begin
                check_mem_req("mem_req_o held", mem_req_o, last_req);
            end
            if (mem_req_o.req && mem_rsp_i.gnt) begin
                if (exp_addr_q.size() == 0) begin
                    $display("Memory request granted with no walking transaction pending");
                    fail_stop();
                end
                exp_req.req  = 1'b1;
                exp_req.addr = exp_addr_q.pop_front();
                check_mem_req("mem_req_o", mem_req_o, exp_req);
            end
            req_waiting = mem_req_o.req && !mem_rsp_i.gnt;
            last_req    = mem_req_o;
            // Stalled output stays valid and stable
            if (out_stalled) begin
                check_bit("out_valid_o", out_valid_o, 1'b1);
                check_txn("out_txn_o held", out_txn_o, last_out);
            end
            if (out_valid_o && out_ready_i) begin
                if (exp_txn_q.size() == 0) begin
                    $display("Output transfer with no transaction pending");
                    fail_stop();
                end
                check_txn("out_txn_o", out_txn_o, expected_output(exp_txn_q.pop_front()));
                delivered = delivered + 1;
            end
            out_stalled = out_valid_o && !out_ready_i;
            last_out    = out_txn_o;
            // Both queues plus the input register
            if (accepted - delivered > TXN_FIFO_DEPTH + 1) begin
                $display("More transactions in flight than the stage can hold");
                fail_stop();
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Reset and end of run
    ////////////////////////////////////////////////////////////

    initial begin : run_test
        int wait_cnt;
        seed         = 32'h7cfd_9b17;
        started      = 1'b0;
        cycle        = 0;
        last_due     = 0;
        sent         = 0;
        accepted     = 0;
        delivered    = 0;
        in_stall_cnt = 0;
        req_waiting  = 1'b0;
        out_stalled  = 1'b0;
        last_req     = '0;
        last_out     = '0;
        rst_ni       = 1'b0;
        in_valid_i   = 1'b0;
        in_txn_i     = '0;
        out_ready_i  = 1'b0;
        mem_rsp_i    = '0;
        repeat (10) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(posedge clk_i);
        // Quiet ports before any traffic
        check_bit("in_ready_o", in_ready_o, 1'b0);
        check_bit("out_valid_o", out_valid_o, 1'b0);
        check_bit("mem_req_o.req", mem_req_o.req, 1'b0);
        started <= 1'b1;
        wait_cnt = 0;
        while (delivered < NUM_TXN) begin
            @(posedge clk_i);
            wait_cnt = wait_cnt + 1;
            if (wait_cnt > END_TIMEOUT) begin
                $display("Timeout waiting for all transactions at the output");
                fail_stop();
            end
        end
        if (exp_addr_q.size() != 0) begin
            $display("Walking transaction finished without a granted memory request");
            fail_stop();
        end
        if (rsp_data_q.size() != 0) begin
            $display("Read responses left over after the last transaction");
            fail_stop();
        end
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
common/mem_pkg.sv
common/mpt_pkg.sv
rtl/transaction_fifo.sv
rtl/req_register.sv
rtl/grant_ctrl.sv
rtl/response_ctrl.sv
rtl/memory_read_stage.sv
dv/tb_memory_read_stage.sv
